// ==== test/mem_cases.txt ====
# test port op addr be wdata exp_rdata exp_err exp_led   (values after addr in hex)
# port 0 instr, 1 data, 2 both with instr read and data retry; op 0 read, 1 write
1 1 1 00000100 f 12345678 00000000 0 2
1 1 0 00000100 0 00000000 12345678 0 2
1 0 0 00000100 0 00000000 12345678 0 2
1 0 0 00000100 0 00000000 12345678 0 2
1 1 1 00000104 f cafef00d 00000000 0 a
1 0 0 00000104 0 00000000 cafef00d 0 a
1 1 0 00000104 0 00000000 cafef00d 0 a
2 1 1 00000200 f 11223344 00000000 0 1
2 1 1 00000200 1 aabbccdd 00000000 0 d
2 1 1 00000200 4 55667788 00000000 0 6
2 1 1 00000200 a 99887766 00000000 0 9
2 1 0 00000200 0 00000000 996677dd 0 9
2 1 1 00000204 f deadbeef 00000000 0 e
2 1 1 00000204 6 01234567 00000000 0 3
2 0 0 00000204 0 00000000 de2345ef 0 3
2 1 0 00000204 0 00000000 de2345ef 0 3
3 1 1 00010200 f ffffffff 00000000 1 3
3 1 0 00010200 0 00000000 00000000 1 3
3 0 0 80000204 0 00000000 00000000 1 3
3 1 1 fffffffc 8 a5000000 00000000 1 3
3 1 0 00000200 0 00000000 996677dd 0 3
3 0 0 00000204 0 00000000 de2345ef 0 3
4 2 1 00000100 3 0000beef 12345678 0 e
4 1 0 00000100 0 00000000 1234beef 0 e
4 2 0 00000104 0 00000000 cafef00d 0 e
4 2 1 00010000 f 77777777 00000000 1 e
5 1 1 00000300 0 ffffffff 00000000 0 e
5 1 1 00000300 f 87654321 00000000 0 7
5 1 1 00000300 0 ffffffff 00000000 0 7
5 1 0 00000300 0 00000000 87654321 0 7
5 1 1 00000300 2 0000a500 00000000 0 5
5 0 0 00000300 0 00000000 8765a521 0 5
5 1 1 00000300 1 000000fc 00000000 0 c
5 1 0 00000300 0 00000000 8765a5fc 0 c
5 1 1 00020300 f 0000000f 00000000 1 c
5 0 0 00000300 0 00000000 8765a5fc 0 c

// ==== compile.f ====
common/mem_pkg.sv
hdl/ram_1p.sv
hdl/mem_arbiter.sv
hdl/mem_subsys_top.sv
test/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_mem_subsys
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_mem_subsys.sv ====
//--------------------------------------------------------------------------
// Testbench for mem_subsys_top with the default 64 kB window at address 0.
// Run from the project root. Directed cases come from test/mem_cases.txt.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

  localparam int                 FILL_WORDS = 16;
  localparam int                 NUM_RANDOM = 200;
  localparam logic [31:0]        RAND_BASE  = 32'h0000_4000;
  localparam mem_pkg::host_req_t IDLE_REQ   = '0;

  // One directed access from the cases file
  typedef struct packed {
    logic [7:0]  test;
    logic [1:0]  port;
    logic        op;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
    logic [3:0]  exp_led;
  } case_t;

  // Response expected one cycle after a random access
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic        chk_data;
    logic [31:0] rdata;
    logic [3:0]  led;
  } pend_t;

  logic               clk_sys = 1'b0;
  logic               rst_sys_n;
  mem_pkg::host_req_t instr_req;
  mem_pkg::host_req_t data_req;
  mem_pkg::host_rsp_t instr_rsp;
  mem_pkg::host_rsp_t data_rsp;
  logic [3:0]         led;

  case_t       case_list[$];
  logic        cases_loaded = 1'b0;
  logic [31:0] lfsr_state   = 32'hf2b7_ff9d;
  logic [31:0] model_mem [FILL_WORDS];
  logic [3:0]  led_expect;
  int          error_count  = 0;
  int          test_errors  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;

  always #5 clk_sys = ~clk_sys;

  mem_subsys_top #(
    .MEM_BYTES (mem_pkg::DEFAULT_MEM_BYTES),
    .MEM_START (mem_pkg::DEFAULT_MEM_START)
  ) u_mem_subsys_top (
    .clk_sys     (clk_sys),
    .rst_sys_n   (rst_sys_n),
    .instr_req_i (instr_req),
    .data_req_i  (data_req),
    .instr_rsp_o (instr_rsp),
    .data_rsp_o  (data_rsp),
    .led_o       (led)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  // Enabled bytes replace the old ones
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Low nibble of the highest enabled byte
  function automatic logic [3:0] led_after(input logic [3:0]  cur,
                                           input logic [3:0]  be,
                                           input logic [31:0] w);
    if (be[3]) return w[27:24];
    else if (be[2]) return w[19:16];
    else if (be[1]) return w[11:8];
    else if (be[0]) return w[3:0];
    else return cur;
  endfunction

  function automatic string test_name(input logic [7:0] num);
    case (num)
      8'd0:    return "reset state";
      8'd1:    return "full-word round trip";
      8'd2:    return "byte-enable merge";
      8'd3:    return "out-of-window access";
      8'd4:    return "priority";
      8'd5:    return "LED capture";
      8'd6:    return "random back-to-back";
      default: return "unnamed";
    endcase
  endfunction

  task automatic note_error();
    error_count++;
    test_errors++;
  endtask

  task automatic check_grant(input string tag, input mem_pkg::host_rsp_t rsp,
                             input logic exp_err, input logic chk_data,
                             input logic [31:0] exp_rdata);
    assert (rsp.gnt === 1'b1 && rsp.rvalid === 1'b1) else begin
      $display("ERROR %0t: %s gnt/rvalid %b/%b, expected 1/1",
               $time, tag, rsp.gnt, rsp.rvalid);
      note_error();
    end
    assert (rsp.err === exp_err) else begin
      $display("ERROR %0t: %s err %b, expected %b", $time, tag, rsp.err, exp_err);
      note_error();
    end
    if (chk_data) begin
      assert (rsp.rdata === exp_rdata) else begin
        $display("ERROR %0t: %s rdata %h, expected %h",
                 $time, tag, rsp.rdata, exp_rdata);
        note_error();
      end
    end
  endtask

  // Port that was not served must stay quiet
  task automatic check_silent(input string tag, input mem_pkg::host_rsp_t rsp);
    assert (rsp.gnt === 1'b0 && rsp.rvalid === 1'b0 && rsp.err === 1'b0) else begin
      $display("ERROR %0t: %s gnt/rvalid/err %b/%b/%b, expected 0/0/0",
               $time, tag, rsp.gnt, rsp.rvalid, rsp.err);
      note_error();
    end
  endtask

  task automatic check_led(input string tag, input logic [3:0] exp_led);
    assert (led === exp_led) else begin
      $display("ERROR %0t: %s led %h, expected %h", $time, tag, led, exp_led);
      note_error();
    end
  endtask

  task automatic report_test(input logic [7:0] num);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("Test %0d (%s): FAIL, %0d errors", num, test_name(num), test_errors);
    end else begin
      $display("Test %0d (%s): ok", num, test_name(num));
    end
    test_errors = 0;
  endtask

  task automatic load_cases(output logic ok);
    int          fd;
    int          rc;
    int          n;
    string       line;
    logic [7:0]  f_test;
    logic [1:0]  f_port;
    logic        f_op;
    logic [31:0] f_addr;
    logic [3:0]  f_be;
    logic [31:0] f_wdata;
    logic [31:0] f_rdata;
    logic        f_err;
    logic [3:0]  f_led;
    case_t       c;
    ok = 1'b1;
    fd = $fopen("test/mem_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/mem_cases.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        // Skip comments and empty lines
        if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %h %h %h %h %d %h", f_test, f_port, f_op,
                      f_addr, f_be, f_wdata, f_rdata, f_err, f_led);
          if (n == 9) begin
            c.test      = f_test;
            c.port      = f_port;
            c.op        = f_op;
            c.addr      = f_addr;
            c.be        = f_be;
            c.wdata     = f_wdata;
            c.exp_rdata = f_rdata;
            c.exp_err   = f_err;
            c.exp_led   = f_led;
            case_list.push_back(c);
          end else begin
            $display("Malformed line in case file: %s", line);
            ok = 1'b0;
          end
        end
      end
      $fclose(fd);
      if (case_list.size() == 0) begin
        $display("Case file holds no cases");
        ok = 1'b0;
      end
    end
  endtask

  task automatic run_case(input case_t c);
    mem_pkg::host_req_t rd_req;
    mem_pkg::host_req_t dt_req;
    string              tag;
    logic               chk_data;
    tag = $sformatf("test %0d at %h", c.test, c.addr);
    rd_req      = IDLE_REQ;
    rd_req.req  = 1'b1;
    rd_req.addr = c.addr;
    dt_req       = rd_req;
    dt_req.we    = c.op;
    dt_req.be    = c.be;
    dt_req.wdata = c.wdata;
    // A write returns the old word, so rdata is known only for reads and errors
    chk_data = ~c.op | c.exp_err;
    case (c.port)
      2'd0: begin
        instr_req = rd_req;
        @(negedge clk_sys);
        check_grant({tag, " instr"}, instr_rsp, c.exp_err, 1'b1, c.exp_rdata);
        check_silent({tag, " data"}, data_rsp);
        instr_req = IDLE_REQ;
      end
      2'd1: begin
        data_req = dt_req;
        @(negedge clk_sys);
        check_grant({tag, " data"}, data_rsp, c.exp_err, chk_data, c.exp_rdata);
        check_silent({tag, " instr"}, instr_rsp);
        data_req = IDLE_REQ;
      end
      default: begin
        // Data loses to instruction fetch and retries
        instr_req = rd_req;
        data_req  = dt_req;
        @(negedge clk_sys);
        check_grant({tag, " instr"}, instr_rsp, c.exp_err, 1'b1, c.exp_rdata);
        check_silent({tag, " data lost"}, data_rsp);
        check_led({tag, " data lost"}, led_expect);
        instr_req = IDLE_REQ;
        @(negedge clk_sys);
        check_grant({tag, " data retry"}, data_rsp, c.exp_err, chk_data, c.exp_rdata);
        check_silent({tag, " instr"}, instr_rsp);
        data_req = IDLE_REQ;
      end
    endcase
    check_led(tag, c.exp_led);
    led_expect = c.exp_led;
  endtask

  task automatic check_pending(input pend_t p);
    if (p.instr) begin
      check_grant("random instr", instr_rsp, 1'b0, p.chk_data, p.rdata);
      check_silent("random data", data_rsp);
    end else begin
      check_grant("random data", data_rsp, 1'b0, p.chk_data, p.rdata);
      check_silent("random instr", instr_rsp);
    end
    check_led("random", p.led);
  endtask

  // Full-word fill of a small region and then one random access per cycle
  task automatic run_random();
    pend_t       pend;
    logic [31:0] r;
    logic        is_write;
    logic        use_instr;
    logic [3:0]  word;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [3:0]  led_model;
    pend      = '0;
    led_model = led_expect;
    for (int k = 0; k < FILL_WORDS + NUM_RANDOM; k++) begin
      @(negedge clk_sys);
      if (pend.valid) begin
        check_pending(pend);
      end
      if (k < FILL_WORDS) begin
        is_write = 1'b1;
        word     = 4'(k);
        be       = 4'hf;
      end else begin
        r        = rand_bits(1);
        is_write = r[0];
        r        = rand_bits(4);
        word     = r[3:0];
        r        = rand_bits(4);
        be       = r[3:0];
      end
      wdata     = rand_bits(32);
      r         = rand_bits(1);
      use_instr = ~is_write & r[0];
      pend.valid    = 1'b1;
      pend.instr    = use_instr;
      pend.chk_data = ~is_write;
      pend.rdata    = model_mem[word];
      if (is_write) begin
        model_mem[word] = merge_bytes(model_mem[word], wdata, be);
        led_model       = led_after(led_model, be, wdata);
      end
      pend.led  = led_model;
      instr_req = IDLE_REQ;
      data_req  = IDLE_REQ;
      if (use_instr) begin
        instr_req.req  = 1'b1;
        instr_req.addr = RAND_BASE | {26'd0, word, 2'b00};
      end else begin
        data_req.req   = 1'b1;
        data_req.we    = is_write;
        data_req.be    = be;
        data_req.addr  = RAND_BASE | {26'd0, word, 2'b00};
        data_req.wdata = wdata;
      end
    end
    @(negedge clk_sys);
    check_pending(pend);
    instr_req  = IDLE_REQ;
    data_req   = IDLE_REQ;
    led_expect = led_model;
  endtask

  task automatic run_all();
    logic [7:0] cur_test;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    rst_sys_n  = 1'b1;
    led_expect = 4'h0;
    check_silent("reset instr", instr_rsp);
    check_silent("reset data", data_rsp);
    check_led("reset", 4'h0);
    report_test(8'd0);
    cur_test = case_list[0].test;
    foreach (case_list[i]) begin
      if (case_list[i].test != cur_test) begin
        report_test(cur_test);
        cur_test = case_list[i].test;
      end
      run_case(case_list[i]);
    end
    report_test(cur_test);
    run_random();
    report_test(8'd6);
    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  initial begin : main
    logic ok;
    $timeformat(-9, 0, " ns", 0);
    instr_req = IDLE_REQ;
    data_req  = IDLE_REQ;
    rst_sys_n = 1'b0;
    load_cases(ok);
    if (!ok) begin
      $display("Case file could not be used, no tests were run");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      run_all();
    end
  end

  // Four cycles per access is well above what any case needs
  initial begin : watchdog
    int limit_cycles;
    wait (cases_loaded);
    limit_cycles = (case_list.size() + FILL_WORDS + NUM_RANDOM) * 4 + 20;
    repeat (limit_cycles) @(posedge clk_sys);
    $display("Timeout: the run did not finish within %0d clock cycles", limit_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/mem_subsys_top.sv ====
//--------------------------------------------------------------------------
// Two host ports on one SRAM. Every request is answered one cycle later,
// unless it lost arbitration. MEM_BYTES must be a power of two.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
  parameter int          MEM_BYTES = mem_pkg::DEFAULT_MEM_BYTES,
  parameter logic [31:0] MEM_START = mem_pkg::DEFAULT_MEM_START
) (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  mem_pkg::host_req_t instr_req_i,
  input  mem_pkg::host_req_t data_req_i,
  output mem_pkg::host_rsp_t instr_rsp_o,
  output mem_pkg::host_rsp_t data_rsp_o,
  output logic [3:0]         led_o
);

  // Word-wide RAM covers the whole window
  localparam int DEPTH_WORDS = MEM_BYTES / 4;

  mem_pkg::mem_cmd_t ram_cmd;
  logic              ram_rvalid;
  logic [31:0]       ram_rdata;

  mem_arbiter #(
    .MEM_BYTES (MEM_BYTES),
    .MEM_START (MEM_START)
  ) u_arbiter (
    .clk_sys      (clk_sys),
    .rst_sys_n    (rst_sys_n),
    .instr_req_i  (instr_req_i),
    .data_req_i   (data_req_i),
    .instr_rsp_o  (instr_rsp_o),
    .data_rsp_o   (data_rsp_o),
    .cmd_o        (ram_cmd),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .led_o        (led_o)
  );

  // Shared instruction and data storage
  ram_1p #(
    .DEPTH_WORDS (DEPTH_WORDS)
  ) u_ram (
    .clk_sys   (clk_sys),
    .rst_sys_n (rst_sys_n),
    .cmd_i     (ram_cmd),
    .rvalid_o  (ram_rvalid),
    .rdata_o   (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== hdl/mem_arbiter.sv ====
//--------------------------------------------------------------------------
// Fixed priority, instruction fetch over data. MEM_BYTES must be a power of
// two and MEM_START aligned to it. Out-of-window requests get an error.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
  parameter int          MEM_BYTES = mem_pkg::DEFAULT_MEM_BYTES,
  parameter logic [31:0] MEM_START = mem_pkg::DEFAULT_MEM_START
) (
  input  logic               clk_sys,
  input  logic               rst_sys_n,
  input  mem_pkg::host_req_t instr_req_i,
  input  mem_pkg::host_req_t data_req_i,
  output mem_pkg::host_rsp_t instr_rsp_o,
  output mem_pkg::host_rsp_t data_rsp_o,
  output mem_pkg::mem_cmd_t  cmd_o,
  input  logic               ram_rvalid_i,
  input  logic [31:0]        ram_rdata_i,
  output logic [3:0]         led_o
);

  localparam logic [31:0] ADDR_MASK = 32'(MEM_BYTES - 1);

  logic                sel_instr;
  logic                sel_data;
  logic                any_req;
  logic [31:0]         sel_addr;
  logic                in_window;
  mem_pkg::grant_src_e src_d;
  mem_pkg::grant_src_e src_q;
  logic                oow_d;
  logic                oow_q;
  logic                led_wr;
  logic [3:0]          led_d;
  logic [3:0]          led_q;

  // Response for one port, zero unless that port was served last cycle
  function automatic mem_pkg::host_rsp_t form_rsp(
    input logic        hit,
    input logic        oow,
    input logic        ram_valid,
    input logic [31:0] ram_data
  );
    mem_pkg::host_rsp_t rsp;
    rsp.gnt    = hit;
    rsp.rvalid = hit & (oow | ram_valid);
    rsp.err    = hit & oow;
    rsp.rdata  = (hit && !oow) ? ram_data : 32'h0;
    return rsp;
  endfunction

  // Instruction fetch wins when both ports request
  assign sel_instr = instr_req_i.req;
  assign sel_data  = data_req_i.req & ~instr_req_i.req;
  assign any_req   = instr_req_i.req | data_req_i.req;
  assign sel_addr  = sel_instr ? instr_req_i.addr : data_req_i.addr;

  // Window check on the upper address bits
  assign in_window = (sel_addr & ~ADDR_MASK) == MEM_START;

  // RAM is only touched for in-window accesses
  always_comb begin
    cmd_o.req       = any_req & in_window;
    cmd_o.we        = sel_data & data_req_i.we;
    cmd_o.be        = sel_data ? data_req_i.be : 4'b0000;
    cmd_o.word_addr = sel_addr[31:2];
    cmd_o.wdata     = sel_data ? data_req_i.wdata : 32'h0;
  end

  always_comb begin
    if (sel_instr) begin
      src_d = mem_pkg::SRC_INSTR;
    end else if (sel_data) begin
      src_d = mem_pkg::SRC_DATA;
    end else begin
      src_d = mem_pkg::SRC_NONE;
    end
  end

  assign oow_d = any_req & ~in_window;

  // Remember who was served and whether it missed the window
  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      src_q <= mem_pkg::SRC_NONE;
      oow_q <= 1'b0;
    end else begin
      src_q <= src_d;
      oow_q <= oow_d;
    end
  end

  // Grant, valid and data go back to the recorded port only
  assign instr_rsp_o = form_rsp(src_q == mem_pkg::SRC_INSTR, oow_q,
                                ram_rvalid_i, ram_rdata_i);
  assign data_rsp_o  = form_rsp(src_q == mem_pkg::SRC_DATA, oow_q,
                                ram_rvalid_i, ram_rdata_i);

  // LED capture on a granted in-window data write
  assign led_wr = sel_data & data_req_i.we & in_window;

  // Highest enabled byte wins, low nibble only
  always_comb begin
    led_d = led_q;
    for (int i = 0; i < 4; i++) begin
      if (data_req_i.be[i]) begin
        led_d = data_req_i.wdata[i*8 +: 4];
      end
    end
  end

  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      led_q <= 4'b0000;
    end else if (led_wr) begin
      led_q <= led_d;
    end
  end

  assign led_o = led_q;

endmodule

`default_nettype wire

// ==== hdl/ram_1p.sv ====
//--------------------------------------------------------------------------
// Single-port RAM, contents undefined at power-up. DEPTH_WORDS must be a
// power of two and at least 2. Upper word_addr bits are ignored.
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_1p #(
  parameter int DEPTH_WORDS = mem_pkg::DEFAULT_MEM_BYTES / 4
) (
  input  logic              clk_sys,
  input  logic              rst_sys_n,
  input  mem_pkg::mem_cmd_t cmd_i,
  output logic              rvalid_o,
  output logic [31:0]       rdata_o
);

  localparam int AW = $clog2(DEPTH_WORDS);

  logic [31:0]   mem [DEPTH_WORDS];
  logic [AW-1:0] idx;
  logic          rvalid_q;
  logic [31:0]   rdata_q;

  // Wraps inside the array
  assign idx = cmd_i.word_addr[AW-1:0];

  // Byte-lane writes, old word read out on the same request
  always_ff @(posedge clk_sys) begin
    if (cmd_i.req) begin
      rdata_q <= mem[idx];
      if (cmd_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (cmd_i.be[b]) begin
            mem[idx][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  // One cycle behind the request
  always_ff @(posedge clk_sys or negedge rst_sys_n) begin
    if (!rst_sys_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= cmd_i.req;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== common/mem_pkg.sv ====
//--------------------------------------------------------------------------
// Shared types for the two-host memory subsystem. Request fields must stay
// stable for the cycle that req is high. Instruction requests are reads.
//--------------------------------------------------------------------------
`default_nettype none

package mem_pkg;

  // Default SRAM window, 64 kB from address zero
  parameter int          DEFAULT_MEM_BYTES = 65536;
  parameter logic [31:0] DEFAULT_MEM_START = 32'h0000_0000;

  // One request from a host port
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } host_req_t;

  // Answer to a host, all fields valid one cycle after the request
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } host_rsp_t;

  // Arbiter to RAM command
  // word_addr is the byte address without its two low bits
  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [29:0] word_addr;
    logic [31:0] wdata;
  } mem_cmd_t;

  // Host served in the previous cycle
  typedef enum logic [1:0] {
    SRC_NONE  = 2'd0,
    SRC_INSTR = 2'd1,
    SRC_DATA  = 2'd2
  } grant_src_e;

endpackage

`default_nettype wire
